// ==== core_top.f ====
+incdir+source
source/core_pkg.sv
source/inst_sram.sv
source/core_ifu.sv
source/core_idu.sv
source/core_exu.sv
source/core_lsu.sv
source/core_csr.sv
source/core_regfile.sv
source/core_top.sv
verif/core_tb.sv

// ==== verif/core_tb.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb;
  import core_pkg::*;

  localparam logic [6:0] op_imm    = 7'h13;
  localparam logic [6:0] op_reg    = 7'h33;
  localparam logic [6:0] op_lui    = 7'h37;
  localparam logic [6:0] op_auipc  = 7'h17;
  localparam logic [6:0] op_jal    = 7'h6f;
  localparam logic [6:0] op_jalr   = 7'h67;
  localparam logic [6:0] op_branch = 7'h63;
  localparam logic [6:0] op_load   = 7'h03;
  localparam logic [6:0] op_store  = 7'h23;
  localparam logic [6:0] op_system = 7'h73;
  localparam inst_t      nop       = 32'h0000_0013;

  logic                     clk_i;
  logic                     reset_i;
  logic                     run_i;
  logic                     imem_we_i;
  logic [`CORE_IMEM_AW-1:0] imem_waddr_i;
  inst_t                    imem_wdata_i;
  reg_addr_t                dbg_raddr_i;
  xlen_t                    dbg_rdata_o;
  logic                     commit_o;
  pc_t                      pc_o;
  inst_t                    inst_o;

  integer seed = 32'habef_3aec;

  inst_t prog [32];         // program image shared with the model
  int    n_emit;
  pc_t   pc_trace [$];      // pc_o of each commit in the last run

  // instruction-level reference model
  xlen_t m_regs [32];
  xlen_t m_mem [256];       // doubleword index
  xlen_t m_csr [4096];
  pc_t   m_pc;

  core_top i_core_top (
    .clk_i(clk_i), .reset_i(reset_i), .run_i(run_i),
    .imem_we_i(imem_we_i), .imem_waddr_i(imem_waddr_i), .imem_wdata_i(imem_wdata_i),
    .dbg_raddr_i(dbg_raddr_i), .dbg_rdata_o(dbg_rdata_o),
    .commit_o(commit_o), .pc_o(pc_o), .inst_o(inst_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check(input string name, input xlen_t actual, input xlen_t expected);
    if (actual !== expected) begin
      report_failure($sformatf("Mismatch at %0t ns: %s = %h, expected %h",
                               $time, name, actual, expected));
    end
  endtask

  function automatic inst_t enc_i(input logic [31:0] imm, rs1, f3, rd, input logic [6:0] op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic inst_t enc_r(input logic [31:0] f7, rs2, rs1, f3, rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], op_reg};
  endfunction

  function automatic inst_t enc_s(input logic [31:0] imm, rs2, rs1, f3);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], op_store};
  endfunction

  function automatic inst_t enc_b(input logic [31:0] imm, rs2, rs1, f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], op_branch};
  endfunction

  function automatic inst_t enc_j(input logic [31:0] imm, rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
  endfunction

  function automatic inst_t enc_u(input logic [31:0] imm20, rd, input logic [6:0] op);
    return {imm20[19:0], rd[4:0], op};
  endfunction

  task automatic clear_prog();
    int a;
    for (a = 0; a < 32; a++) prog[a] = nop;
    n_emit = 0;
  endtask

  task automatic emit(input inst_t w);
    prog[n_emit] = w;
    n_emit++;
  endtask

  // executes one instruction at m_pc by the rv64i rules
  task automatic model_step();
    inst_t       in;
    xlen_t       a;
    xlen_t       b;
    xlen_t       imm;
    xlen_t       addr;
    xlen_t       res;
    pc_t         npc;
    logic        wr;
    logic [11:0] csr;
    in  = prog[m_pc[6:2]];
    a   = m_regs[in[19:15]];
    b   = m_regs[in[24:20]];
    imm = {{52{in[31]}}, in[31:20]};
    csr = in[31:20];
    npc = m_pc + 4;
    wr  = 1'b0;
    res = '0;
    case (in[6:0])
      op_imm: begin
        wr  = 1'b1;
        res = (in[14:12] == 3'd1) ? a << in[25:20] : a + imm;
      end
      op_reg: begin
        wr = 1'b1;
        case (in[14:12])
          3'd0:    res = in[30] ? a - b : a + b;
          3'd4:    res = a ^ b;
          3'd6:    res = a | b;
          default: res = a & b;
        endcase
      end
      op_lui, op_auipc: begin
        wr  = 1'b1;
        res = {{32{in[31]}}, in[31:12], 12'h000} + (in[5] ? 64'd0 : m_pc);
      end
      op_jal, op_jalr: begin
        wr  = 1'b1;
        res = m_pc + 4;
        npc = in[3] ? m_pc + {{43{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0}
                    : (a + imm) & ~64'd1;
      end
      op_branch: begin
        if ((a == b) != in[12])   // beq when funct3 bit 0 clear, else bne
          npc = m_pc + {{51{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
      end
      op_load: begin
        wr   = 1'b1;
        addr = a + imm;
        res  = m_mem[addr[10:3]];
        if (!in[12]) res = addr[2] ? {{32{res[63]}}, res[63:32]} : {{32{res[31]}}, res[31:0]};
      end
      op_store: begin
        addr = a + {{52{in[31]}}, in[31:25], in[11:7]};
        if (in[12]) m_mem[addr[10:3]] = b;
        else if (addr[2]) m_mem[addr[10:3]][63:32] = b[31:0];
        else m_mem[addr[10:3]][31:0] = b[31:0];
      end
      op_system: begin
        if (in[14:12] == 3'd1) begin
          wr  = 1'b1;
          res = m_csr[csr];
          if (csr == 12'h305 || csr == 12'h341 || csr == 12'h342) m_csr[csr] = a;
        end else if (csr == 12'h000) begin
          m_csr[12'h341] = m_pc;   // ecall
          m_csr[12'h342] = 64'd11;
          npc = m_csr[12'h305];
        end else begin
          npc = m_csr[12'h341];    // mret
        end
      end
      default: ;
    endcase
    if (wr && in[11:7] != 5'd0) m_regs[in[11:7]] = res;
    m_pc = npc;
  endtask

  task automatic load_program();
    int a;
    @(posedge clk_i);
    run_i <= 1'b0;
    for (a = 0; a < 32; a++) begin
      imem_we_i    <= 1'b1;
      imem_waddr_i <= a[7:0];
      imem_wdata_i <= prog[a];
      @(posedge clk_i);
    end
    imem_we_i <= 1'b0;
  endtask

  task automatic apply_reset();
    int i;
    @(posedge clk_i);
    reset_i <= 1'b1;
    run_i   <= 1'b0;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
    m_pc = `CORE_RESET_PC;
    for (i = 0; i < 4096; i++) m_csr[i] = '0;
  endtask

  task automatic start_program();
    load_program();
    apply_reset();
  endtask

  // runs n commits and checks each against the model
  task automatic run_until(input int n);
    int commits;
    int cycles;
    commits = 0;
    cycles  = 0;
    pc_trace.delete();
    @(posedge clk_i);
    run_i <= 1'b1;
    while (commits < n) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > 4 * n + 200)
        report_failure($sformatf("Core hung: only %0d of %0d instructions committed",
                                 commits, n));
      if (commit_o) begin
        pc_trace.push_back(pc_o);
        check("pc_o", pc_o, m_pc);
        check("inst_o", inst_o, prog[m_pc[6:2]]);
        model_step();
        commits++;
      end
    end
    @(posedge clk_i);   // closing edge of the last commit
    run_i <= 1'b0;
  endtask

  task automatic read_reg(input int idx, output xlen_t val);
    @(posedge clk_i);
    dbg_raddr_i <= idx[4:0];
    @(negedge clk_i);
    val = dbg_rdata_o;
  endtask

  task automatic check_regs();
    int    r;
    xlen_t v;
    for (r = 0; r < 32; r++) begin
      read_reg(r, v);
      check($sformatf("x%0d", r), v, m_regs[r]);
    end
  endtask

  task automatic test_reset();
    int k;
    apply_reset();
    repeat (4) begin
      @(negedge clk_i);
      check("commit_o after reset", commit_o, 0);
    end
    clear_prog();
    for (k = 1; k < 32; k++) emit(enc_i(0, 0, 0, k, op_imm));   // clear x1..x31
    start_program();
    run_until(31);
    check("first pc_o", pc_trace[0], `CORE_RESET_PC);
    check_regs();
  endtask

  task automatic test_alu();
    int    k;
    xlen_t v;
    clear_prog();
    for (k = 1; k <= 4; k++) emit(enc_i($random(seed), 0, 0, k, op_imm));
    emit(enc_i($random(seed) & 63, 1, 1, 5, op_imm));   // slli
    emit(enc_r(0, 2, 1, 0, 6));
    emit(enc_r(32, 3, 5, 0, 7));                        // sub
    emit(enc_r(0, 4, 6, 7, 8));
    emit(enc_r(0, 7, 2, 6, 9));
    emit(enc_r(0, 9, 5, 4, 10));
    emit(enc_u($random(seed), 11, op_lui));
    emit(enc_u($random(seed), 12, op_auipc));
    emit(enc_i($random(seed), 3, 0, 0, op_imm));        // x0 target
    emit(enc_r(0, 2, 1, 0, 0));
    start_program();
    run_until(n_emit);
    check_regs();
    read_reg(0, v);
    check("x0", v, 0);
  endtask

  task automatic test_control();
    int    k;
    int    exp_pc [9];
    xlen_t v;
    clear_prog();
    emit(enc_i(5, 0, 0, 1, op_imm));
    emit(enc_i(5, 0, 0, 2, op_imm));
    emit(enc_b(8, 2, 1, 0));          // beq taken
    emit(enc_i(1, 0, 0, 3, op_imm));
    emit(enc_b(8, 2, 1, 1));          // bne not taken
    emit(enc_j(12, 4));
    emit(enc_i(2, 0, 0, 5, op_imm));
    emit(enc_i(3, 0, 0, 6, op_imm));
    emit(enc_i('h31, 0, 0, 8, op_imm));
    emit(enc_i(0, 8, 0, 7, op_jalr));  // odd target drops bit 0
    n_emit = 12;
    emit(enc_b(8, 0, 1, 0));          // beq not taken
    emit(enc_i(9, 0, 0, 9, op_imm));
    start_program();
    run_until(9);
    exp_pc = '{'h00, 'h04, 'h08, 'h10, 'h14, 'h20, 'h24, 'h30, 'h34};
    for (k = 0; k < 9; k++) check($sformatf("pc_trace[%0d]", k), pc_trace[k], exp_pc[k]);
    read_reg(4, v);
    check("x4 link", v, 'h18);
    read_reg(7, v);
    check("x7 link", v, 'h28);
    check_regs();
  endtask

  task automatic test_memory();
    xlen_t v4;
    xlen_t v7;
    xlen_t v8;
    xlen_t v9;
    clear_prog();
    emit(enc_i('h100, 0, 0, 1, op_imm));   // base address
    emit(enc_u($random(seed), 2, op_lui));
    emit(enc_i($random(seed), 2, 0, 2, op_imm));
    emit(enc_i(17, 2, 1, 3, op_imm));
    emit(enc_r(0, 2, 3, 4, 3));
    emit(enc_s(8, 3, 1, 3));               // sd
    emit(enc_i(8, 1, 3, 4, op_load));      // ld
    emit(enc_i(-3, 0, 0, 5, op_imm));
    emit(enc_s(16, 5, 1, 2));              // sw low half
    emit(enc_s(20, 2, 1, 2));              // sw high half
    emit(enc_i(16, 1, 2, 7, op_load));
    emit(enc_i(20, 1, 2, 8, op_load));
    emit(enc_i(16, 1, 3, 9, op_load));
    start_program();
    run_until(n_emit);
    check_regs();
    read_reg(4, v4);
    read_reg(7, v7);
    read_reg(8, v8);
    read_reg(9, v9);
    check("ld after sd", v4, m_regs[3]);
    check("lw low half", v7, 64'hffff_ffff_ffff_fffd);
    check("lw high half", v8, {{32{m_regs[2][31]}}, m_regs[2][31:0]});
    check("ld merged", v9, {m_regs[2][31:0], 32'hffff_fffd});
  endtask

  task automatic test_csr();
    xlen_t v;
    clear_prog();
    emit(enc_i('h40, 0, 0, 1, op_imm));
    emit(enc_i('h305, 1, 1, 2, op_system));   // mtvec
    emit(enc_i('h305, 1, 1, 3, op_system));
    emit(32'h0000_0073);                      // ecall at 0x0c
    emit(enc_i(77, 0, 0, 9, op_imm));
    n_emit = 16;                              // handler at 0x40
    emit(enc_i('h341, 0, 1, 4, op_system));
    emit(enc_i('h342, 0, 1, 5, op_system));
    emit(enc_i(4, 4, 0, 6, op_imm));
    emit(enc_i('h341, 6, 1, 0, op_system));
    emit(32'h3020_0073);                      // mret
    start_program();
    run_until(10);
    read_reg(3, v);
    check("old mtvec", v, 'h40);
    check("pc after ecall", pc_trace[4], 'h40);
    read_reg(4, v);
    check("mepc read", v, 'h0c);
    read_reg(5, v);
    check("mcause read", v, 11);
    check("pc after mret", pc_trace[9], 'h10);
    check_regs();
  endtask

  task automatic test_run_pause();
    int    k;
    xlen_t v;
    clear_prog();
    emit(enc_i(1, 0, 0, 10, op_imm));
    for (k = 0; k < 7; k++) emit(enc_i(3, 10, 0, 10, op_imm));
    start_program();
    run_until(3);
    repeat (12) begin
      @(negedge clk_i);
      check("commit_o while stopped", commit_o, 0);
    end
    run_until(5);
    check("pc_o after resume", pc_trace[0], 'h0c);
    read_reg(10, v);
    check("x10", v, 22);
    check_regs();
  endtask

  initial begin
    int i;
    reset_i      = 1'b1;
    run_i        = 1'b0;
    imem_we_i    = 1'b0;
    imem_waddr_i = '0;
    imem_wdata_i = '0;
    dbg_raddr_i  = '0;
    for (i = 0; i < 32; i++) m_regs[i] = '0;
    for (i = 0; i < 256; i++) m_mem[i] = '0;
    test_reset();
    test_alu();
    test_control();
    test_memory();
    test_csr();
    test_run_pause();
    $display("All tests passed!");
    $finish;
  end

endmodule

// ==== source/core_top.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     run_i,
  input  logic                     imem_we_i,
  input  logic [`CORE_IMEM_AW-1:0] imem_waddr_i,
  input  core_pkg::inst_t          imem_wdata_i,
  input  core_pkg::reg_addr_t      dbg_raddr_i,
  output core_pkg::xlen_t          dbg_rdata_o,
  output logic                     commit_o,
  output core_pkg::pc_t            pc_o,
  output core_pkg::inst_t          inst_o
);
  import core_pkg::*;

  // fetch channel
  logic      arvalid;
  logic      arready;
  logic      rvalid;
  logic      rready;
  pc_t       araddr;
  inst_t     rdata;

  fetch_t    fetch;
  decode_t   dec;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     alu_result;
  xlen_t     csr_rdata;
  xlen_t     wb_data;
  logic      csr_redirect;
  pc_t       csr_target;
  logic      reg_we;

  assign reg_we   = fetch.commit & dec.reg_we;
  assign commit_o = fetch.commit;
  assign pc_o     = fetch.pc;
  assign inst_o   = fetch.inst;

  inst_sram i_inst_sram (
    .clk_i(clk_i), .reset_i(reset_i),
    .arvalid_i(arvalid), .araddr_i(araddr), .arready_o(arready),
    .rvalid_o(rvalid), .rready_i(rready), .rdata_o(rdata),
    .load_we_i(imem_we_i), .load_addr_i(imem_waddr_i), .load_data_i(imem_wdata_i)
  );

  core_ifu i_core_ifu (
    .clk_i(clk_i), .reset_i(reset_i), .run_i(run_i),
    .arvalid_o(arvalid), .araddr_o(araddr), .arready_i(arready),
    .rvalid_i(rvalid), .rready_o(rready), .rdata_i(rdata),
    .next_pc_i(dec.next_pc), .csr_redirect_i(csr_redirect),
    .csr_target_i(csr_target), .fetch_o(fetch)
  );

  core_idu i_core_idu (
    .fetch_i(fetch), .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .dec_o(dec)
  );

  core_exu i_core_exu (.dec_i(dec), .result_o(alu_result));

  core_lsu i_core_lsu (
    .clk_i(clk_i), .commit_i(fetch.commit), .dec_i(dec),
    .alu_result_i(alu_result), .csr_rdata_i(csr_rdata), .wb_data_o(wb_data)
  );

  core_csr i_core_csr (
    .clk_i(clk_i), .reset_i(reset_i), .commit_i(fetch.commit), .pc_i(fetch.pc),
    .dec_i(dec), .rs1_data_i(rs1_data), .csr_rdata_o(csr_rdata),
    .csr_redirect_o(csr_redirect), .csr_target_o(csr_target)
  );

  core_regfile i_core_regfile (
    .clk_i(clk_i), .we_i(reg_we), .waddr_i(dec.rd), .wdata_i(wb_data),
    .raddr1_i(rs1_addr), .raddr2_i(rs2_addr),
    .rdata1_o(rs1_data), .rdata2_o(rs2_data),
    .dbg_raddr_i(dbg_raddr_i), .dbg_rdata_o(dbg_rdata_o)
  );

endmodule

// ==== source/core_regfile.sv ====
`timescale 1ns/1ps

module core_regfile (
  input  logic                clk_i,
  input  logic                we_i,
  input  core_pkg::reg_addr_t waddr_i,
  input  core_pkg::xlen_t     wdata_i,
  input  core_pkg::reg_addr_t raddr1_i,
  input  core_pkg::reg_addr_t raddr2_i,
  output core_pkg::xlen_t     rdata1_o,
  output core_pkg::xlen_t     rdata2_o,
  input  core_pkg::reg_addr_t dbg_raddr_i,
  output core_pkg::xlen_t     dbg_rdata_o
);
  import core_pkg::*;

  xlen_t regs [32];

  always_ff @(posedge clk_i) begin
    if (we_i && waddr_i != '0) regs[waddr_i] <= wdata_i;   // x0 stays zero
  end

  assign rdata1_o    = (raddr1_i == '0) ? '0 : regs[raddr1_i];
  assign rdata2_o    = (raddr2_i == '0) ? '0 : regs[raddr2_i];
  assign dbg_rdata_o = (dbg_raddr_i == '0) ? '0 : regs[dbg_raddr_i];

endmodule

// ==== source/core_csr.sv ====
`timescale 1ns/1ps

module core_csr (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              commit_i,
  input  core_pkg::pc_t     pc_i,
  input  core_pkg::decode_t dec_i,
  input  core_pkg::xlen_t   rs1_data_i,
  output core_pkg::xlen_t   csr_rdata_o,
  output logic              csr_redirect_o,
  output core_pkg::pc_t     csr_target_o
);
  import core_pkg::*;

  localparam csr_addr_t addr_mstatus = 12'h300;
  localparam csr_addr_t addr_mtvec   = 12'h305;
  localparam csr_addr_t addr_mepc    = 12'h341;
  localparam csr_addr_t addr_mcause  = 12'h342;

  xlen_t mstatus_q;
  xlen_t mtvec_q;
  xlen_t mepc_q;
  xlen_t mcause_q;
  logic  is_rw;
  logic  is_ecall;
  logic  is_mret;

  assign is_rw    = (dec_i.csr_op == csr_rw);
  assign is_ecall = (dec_i.csr_op == csr_ecall);
  assign is_mret  = (dec_i.csr_op == csr_mret);

  always_comb begin
    case (dec_i.csr_addr)
      addr_mstatus: csr_rdata_o = mstatus_q;
      addr_mtvec:   csr_rdata_o = mtvec_q;
      addr_mepc:    csr_rdata_o = mepc_q;
      addr_mcause:  csr_rdata_o = mcause_q;
      default:      csr_rdata_o = '0;   // unimplemented csr
    endcase
  end

  assign csr_redirect_o = is_ecall | is_mret;
  assign csr_target_o   = is_mret ? mepc_q : mtvec_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mstatus_q <= 64'h0000_0000_0000_1800;   // mpp = m
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (commit_i) begin
      if (is_rw) begin
        case (dec_i.csr_addr)
          addr_mstatus: mstatus_q <= rs1_data_i | 64'h1800;   // only m mode exists
          addr_mtvec:   mtvec_q   <= rs1_data_i;
          addr_mepc:    mepc_q    <= rs1_data_i;
          addr_mcause:  mcause_q  <= rs1_data_i;
          default: ;
        endcase
      end
      if (is_ecall) begin
        mepc_q       <= pc_i;
        mcause_q     <= 64'd11;            // ecall from m mode
        mstatus_q[7] <= mstatus_q[3];      // mpie <= mie
        mstatus_q[3] <= 1'b0;
      end
      if (is_mret) begin
        mstatus_q[3] <= mstatus_q[7];
        mstatus_q[7] <= 1'b1;
      end
    end
  end

endmodule

// ==== source/core_lsu.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_lsu (
  input  logic              clk_i,
  input  logic              commit_i,
  input  core_pkg::decode_t dec_i,
  input  core_pkg::xlen_t   alu_result_i,
  input  core_pkg::xlen_t   csr_rdata_i,
  output core_pkg::xlen_t   wb_data_o
);
  import core_pkg::*;

  xlen_t                   dmem [`CORE_DMEM_WORDS];
  logic [`CORE_DMEM_AW-1:0] idx;
  logic                    half;
  xlen_t                   dword;
  logic [31:0]             word;
  xlen_t                   load_data;

  assign idx   = alu_result_i[`CORE_DMEM_AW+2:3];   // wraps modulo depth
  assign half  = alu_result_i[2];
  assign dword = dmem[idx];
  assign word  = half ? dword[63:32] : dword[31:0];

  always_comb begin
    if (!dec_i.mem_re)                   load_data = '0;
    else if (dec_i.mem_width == mem_word) load_data = {{32{word[31]}}, word};
    else                                 load_data = dword;
  end

  always_ff @(posedge clk_i) begin
    if (commit_i && dec_i.mem_we) begin
      if (dec_i.mem_width == mem_dword) dmem[idx] <= dec_i.store_data;
      else dmem[idx][{half, 5'b0} +: 32] <= dec_i.store_data[31:0];
    end
  end

  // writeback select, absorbs the old wbu
  always_comb begin
    case (dec_i.wb_sel)
      wb_load: wb_data_o = load_data;
      wb_csr:  wb_data_o = csr_rdata_i;
      wb_link: wb_data_o = dec_i.op1 + 64'd4;   // op1 carries pc for jumps
      default: wb_data_o = alu_result_i;
    endcase
  end

endmodule

// ==== source/core_exu.sv ====
`timescale 1ns/1ps

module core_exu (
  input  core_pkg::decode_t dec_i,
  output core_pkg::xlen_t   result_o
);
  import core_pkg::*;

  xlen_t op1;
  xlen_t op2;

  assign op1 = dec_i.op1;
  assign op2 = dec_i.op2;

  always_comb begin
    case (dec_i.alu_op)
      alu_add:   result_o = op1 + op2;
      alu_sub:   result_o = op1 - op2;
      alu_and:   result_o = op1 & op2;
      alu_or:    result_o = op1 | op2;
      alu_xor:   result_o = op1 ^ op2;
      alu_sll:   result_o = op1 << op2[5:0];   // rv64 shamt is 6 bits
      alu_pass2: result_o = op2;                // lui
      default:   result_o = op1 + op2;
    endcase
  end

endmodule

// ==== source/core_idu.sv ====
`timescale 1ns/1ps

module core_idu (
  input  core_pkg::fetch_t    fetch_i,
  output core_pkg::reg_addr_t rs1_addr_o,
  output core_pkg::reg_addr_t rs2_addr_o,
  input  core_pkg::xlen_t     rs1_data_i,
  input  core_pkg::xlen_t     rs2_data_i,
  output core_pkg::decode_t   dec_o
);
  import core_pkg::*;

  inst_t      inst;
  pc_t        pc;
  pc_t        pc_plus4;
  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  decode_t    dec;

  assign inst     = fetch_i.inst;
  assign pc       = fetch_i.pc;
  assign pc_plus4 = pc + 64'd4;
  assign opcode   = inst[6:0];
  assign funct3   = inst[14:12];
  assign funct7   = inst[31:25];

  assign rs1_addr_o = inst[19:15];
  assign rs2_addr_o = inst[24:20];

  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    dec            = '0;
    dec.op1        = rs1_data_i;
    dec.op2        = rs2_data_i;
    dec.alu_op     = alu_add;
    dec.rd         = inst[11:7];
    dec.wb_sel     = wb_alu;
    dec.mem_width  = mem_word;
    dec.store_data = rs2_data_i;
    dec.csr_op     = csr_none;
    dec.csr_addr   = inst[31:20];
    dec.next_pc    = pc_plus4;
    case (opcode)
      7'b0010011: begin   // addi, slli
        dec.op2 = imm_i;
        if (funct3 == 3'b000) begin
          dec.reg_we = 1'b1;
        end else if (funct3 == 3'b001 && funct7[6:1] == 6'b0) begin
          dec.alu_op = alu_sll;
          dec.reg_we = 1'b1;
        end
      end
      7'b0110011: begin
        dec.reg_we = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: dec.alu_op = alu_add;
          10'b0100000_000: dec.alu_op = alu_sub;
          10'b0000000_111: dec.alu_op = alu_and;
          10'b0000000_110: dec.alu_op = alu_or;
          10'b0000000_100: dec.alu_op = alu_xor;
          default:         dec.reg_we = 1'b0;   // unknown r-type, no-op
        endcase
      end
      7'b0110111: begin   // lui
        dec.op2    = imm_u;
        dec.alu_op = alu_pass2;
        dec.reg_we = 1'b1;
      end
      7'b0010111: begin   // auipc
        dec.op1    = pc;
        dec.op2    = imm_u;
        dec.reg_we = 1'b1;
      end
      7'b1101111, 7'b1100111: begin
        dec.op1     = pc;   // lsu forms the link from op1
        dec.op2     = 64'd4;
        dec.reg_we  = 1'b1;
        dec.wb_sel  = wb_link;
        dec.next_pc = (opcode[3]) ? pc + imm_j : (rs1_data_i + imm_i) & ~64'd1;
      end
      7'b1100011: begin
        if ((funct3 == 3'b000 && rs1_data_i == rs2_data_i) ||
            (funct3 == 3'b001 && rs1_data_i != rs2_data_i))
          dec.next_pc = pc + imm_b;
      end
      7'b0000011: begin   // lw, ld
        dec.op2       = imm_i;
        dec.mem_re    = (funct3 == 3'b010) || (funct3 == 3'b011);
        dec.reg_we    = dec.mem_re;
        dec.wb_sel    = wb_load;
        dec.mem_width = funct3[0] ? mem_dword : mem_word;
      end
      7'b0100011: begin   // sw, sd
        dec.op2       = imm_s;
        dec.mem_we    = (funct3 == 3'b010) || (funct3 == 3'b011);
        dec.mem_width = funct3[0] ? mem_dword : mem_word;
      end
      7'b1110011: begin
        if (funct3 == 3'b001) begin
          dec.csr_op = csr_rw;
          dec.reg_we = 1'b1;
          dec.wb_sel = wb_csr;
        end else if (funct3 == 3'b000 && inst[31:20] == 12'h000) begin
          dec.csr_op = csr_ecall;
        end else if (funct3 == 3'b000 && inst[31:20] == 12'h302) begin
          dec.csr_op = csr_mret;
        end
      end
      default: ;          // undefined opcode falls through as nop
    endcase
  end

  assign dec_o = dec;

endmodule

// ==== source/core_ifu.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module core_ifu (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             run_i,
  output logic             arvalid_o,
  output core_pkg::pc_t    araddr_o,
  input  logic             arready_i,
  input  logic             rvalid_i,
  output logic             rready_o,
  input  core_pkg::inst_t  rdata_i,
  input  core_pkg::pc_t    next_pc_i,
  input  logic             csr_redirect_i,
  input  core_pkg::pc_t    csr_target_i,
  output core_pkg::fetch_t fetch_o
);
  import core_pkg::*;

  ifu_state_e state_q;
  pc_t        pc_q;
  logic       beat;

  assign arvalid_o = (state_q == ifu_req);
  assign rready_o  = (state_q == ifu_wait);
  assign araddr_o  = pc_q;
  assign beat      = rready_o & rvalid_i;

  assign fetch_o.pc     = pc_q;
  assign fetch_o.inst   = rdata_i;
  assign fetch_o.commit = beat;   // execute and commit happen on the beat

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ifu_idle;
      pc_q    <= `CORE_RESET_PC;
    end else begin
      case (state_q)
        ifu_idle: if (run_i) state_q <= ifu_req;
        ifu_req:  if (arready_i) state_q <= ifu_wait;
        ifu_wait: begin
          if (beat) begin
            state_q <= ifu_idle;   // re-checks run_i before next fetch
            pc_q    <= csr_redirect_i ? csr_target_i : next_pc_i;
          end
        end
        default:  state_q <= ifu_idle;
      endcase
    end
  end

endmodule

// ==== source/inst_sram.sv ====
`timescale 1ns/1ps
`include "core_params.svh"

module inst_sram (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  logic                     arvalid_i,
  input  core_pkg::pc_t            araddr_i,
  output logic                     arready_o,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  output core_pkg::inst_t          rdata_o,
  input  logic                     load_we_i,
  input  logic [`CORE_IMEM_AW-1:0] load_addr_i,
  input  core_pkg::inst_t          load_data_i
);
  import core_pkg::*;

  inst_t mem [`CORE_IMEM_WORDS];
  inst_t rdata_q;

  assign arready_o = ~rvalid_o;   // one read outstanding at most
  assign rdata_o   = rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_o <= 1'b0;
    end else if (arvalid_i && arready_o) begin
      rvalid_o <= 1'b1;
    end else if (rvalid_o && rready_i) begin
      rvalid_o <= 1'b0;
    end
  end

  // byte address -> word index, response held until rready
  always_ff @(posedge clk_i) begin
    if (arvalid_i && arready_o) rdata_q <= mem[araddr_i[`CORE_IMEM_AW+1:2]];
    if (load_we_i) mem[load_addr_i] <= load_data_i;   // program load port
  end

endmodule

// ==== source/core_pkg.sv ====
`include "core_params.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] xlen_t;
  typedef logic [`CORE_XLEN-1:0] pc_t;
  typedef logic [`CORE_ILEN-1:0] inst_t;
  typedef logic [4:0]            reg_addr_t;
  typedef logic [11:0]           csr_addr_t;

  typedef enum logic [2:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_pass2
  } alu_op_e;

  // writeback source for rd
  typedef enum logic [1:0] {wb_alu, wb_load, wb_csr, wb_link} wb_sel_e;

  typedef enum logic {mem_word, mem_dword} mem_width_e;

  typedef enum logic [1:0] {csr_none, csr_rw, csr_ecall, csr_mret} csr_op_e;

  typedef enum logic [1:0] {ifu_idle, ifu_req, ifu_wait} ifu_state_e;

  typedef struct packed {
    xlen_t      op1;
    xlen_t      op2;
    alu_op_e    alu_op;
    reg_addr_t  rd;
    logic       reg_we;
    wb_sel_e    wb_sel;
    logic       mem_re;
    logic       mem_we;
    mem_width_e mem_width;
    xlen_t      store_data;
    csr_op_e    csr_op;
    csr_addr_t  csr_addr;
    pc_t        next_pc;    // sequential, branch or jump target
  } decode_t;

  typedef struct packed {
    pc_t   pc;
    inst_t inst;
    logic  commit;          // high on the fetch beat only
  } fetch_t;

endpackage

// ==== source/core_params.svh ====
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and instruction widths
`define CORE_XLEN 64
`define CORE_ILEN 32

// first fetch address out of reset
`define CORE_RESET_PC 64'h0000_0000_0000_0000

// instruction sram, 32-bit words
`define CORE_IMEM_WORDS 256
`define CORE_IMEM_AW    8    // log2 of imem depth

// data memory, 64-bit doublewords
`define CORE_DMEM_WORDS 256
`define CORE_DMEM_AW    8

`endif
